// File: source/fft_pkg.sv
/* FFT accelerator constants and types */

package fft_pkg;

  //////////////////////////////////////////////////
  // Transform size and fixed-point format
  //////////////////////////////////////////////////

  localparam int N_POINTS     = 32;
  localparam int LOG2_N       = 5;
  // Q2.14 twiddles, 16384 is unity
  localparam int TWIDDLE_FRAC = 14;
  localparam int BFLY_LATENCY = 3;
  // Start sample to done pulse
  localparam int RUN_CYCLES   = 128;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic signed [15:0] sample_t;
  typedef logic        [4:0]  point_addr_t;
  // Bit 5 set selects the imaginary half
  typedef logic        [5:0]  host_addr_t;
  typedef logic signed [15:0] twiddle_t;
  typedef logic        [3:0]  twiddle_idx_t;
  typedef logic        [2:0]  stage_t;

  // Controller sequencing
  typedef enum logic [2:0] {
    IDLE,
    COPY,
    STAGE,
    DRAIN,
    FINISH
  } ctrl_state_e;

endpackage

// File: source/sample_ram.sv
/* Host sample RAM */

`timescale 1ns/1ps

module sample_ram (
  input  logic                clk,
  input  logic                rst_i,
  input  logic                busy_i,
  input  logic                wr_en_i,
  input  fft_pkg::host_addr_t wr_addr_i,
  input  fft_pkg::sample_t    wr_data_i,
  input  fft_pkg::point_addr_t rd_idx_i,
  output fft_pkg::sample_t    rd_real_o,
  output fft_pkg::sample_t    rd_imag_o
);
  import fft_pkg::*;

  // Separate real and imaginary halves
  sample_t real_mem [N_POINTS];
  sample_t imag_mem [N_POINTS];

  logic wr_ok;

  // Host strobe only counts while idle and out of reset
  assign wr_ok = wr_en_i && !busy_i && !rst_i;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      // Top address bit picks the half
      if (wr_addr_i[LOG2_N]) begin
        imag_mem[wr_addr_i[LOG2_N-1:0]] <= wr_data_i;
      end else begin
        real_mem[wr_addr_i[LOG2_N-1:0]] <= wr_data_i;
      end
    end
  end

  // Copy phase reads in the same cycle
  assign rd_real_o = real_mem[rd_idx_i];
  assign rd_imag_o = imag_mem[rd_idx_i];

endmodule

// File: source/twiddle_rom.sv
/* Twiddle factor ROM */

`timescale 1ns/1ps

module twiddle_rom (
  input  fft_pkg::twiddle_idx_t idx_i,
  output fft_pkg::twiddle_t     cos_o,
  output fft_pkg::twiddle_t     sin_o
);

  // Packed as {cos, -sin}
  logic [31:0] w;

  // W32^k scaled by 16384 and rounded
  always_comb begin
    case (idx_i)
      4'd0:    w = {16'sd16384, 16'sd0};
      4'd1:    w = {16'sd16069, -16'sd3196};
      4'd2:    w = {16'sd15137, -16'sd6270};
      4'd3:    w = {16'sd13623, -16'sd9102};
      4'd4:    w = {16'sd11585, -16'sd11585};
      4'd5:    w = {16'sd9102, -16'sd13623};
      4'd6:    w = {16'sd6270, -16'sd15137};
      4'd7:    w = {16'sd3196, -16'sd16069};
      // Quarter turn
      4'd8:    w = {16'sd0, -16'sd16384};
      4'd9:    w = {-16'sd3196, -16'sd16069};
      4'd10:   w = {-16'sd6270, -16'sd15137};
      4'd11:   w = {-16'sd9102, -16'sd13623};
      4'd12:   w = {-16'sd11585, -16'sd11585};
      4'd13:   w = {-16'sd13623, -16'sd9102};
      4'd14:   w = {-16'sd15137, -16'sd6270};
      default: w = {-16'sd16069, -16'sd3196};
    endcase
  end

  assign cos_o = w[31:16];
  assign sin_o = w[15:0];

endmodule

// File: source/butterfly_unit.sv
/* Pipelined radix-2 butterfly */

`timescale 1ns/1ps

module butterfly_unit (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              valid_i,
  input  fft_pkg::sample_t  a_real_i,
  input  fft_pkg::sample_t  a_imag_i,
  input  fft_pkg::sample_t  b_real_i,
  input  fft_pkg::sample_t  b_imag_i,
  input  fft_pkg::twiddle_t w_cos_i,
  input  fft_pkg::twiddle_t w_sin_i,
  output logic              valid_o,
  output fft_pkg::sample_t  x_real_o,
  output fft_pkg::sample_t  x_imag_o,
  output fft_pkg::sample_t  y_real_o,
  output fft_pkg::sample_t  y_imag_o
);
  import fft_pkg::*;

  // Stage 1 operand registers
  sample_t  a1_r_q, a1_i_q, b1_r_q, b1_i_q;
  twiddle_t w1_c_q, w1_s_q;
  // Stage 2 product and delayed a
  sample_t            a2_r_q, a2_i_q;
  logic signed [17:0] p2_r_q, p2_i_q;
  // Full precision product
  logic signed [32:0] mul_r, mul_i;
  logic signed [32:0] mul_r_sh, mul_i_sh;
  // Stage 3 sums before halving
  logic signed [18:0] sum_x_r, sum_x_i, sum_y_r, sum_y_i;
  logic               v1_q, v2_q, v3_q;

  //////////////////////////////////////////////////
  // Valid pipe
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
      v3_q <= 1'b0;
    end else begin
      v1_q <= valid_i;
      v2_q <= v1_q;
      v3_q <= v2_q;
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // (br + j*bi) * (wc + j*ws)
  assign mul_r    = b1_r_q * w1_c_q - b1_i_q * w1_s_q;
  assign mul_i    = b1_r_q * w1_s_q + b1_i_q * w1_c_q;
  assign mul_r_sh = mul_r >>> TWIDDLE_FRAC;
  assign mul_i_sh = mul_i >>> TWIDDLE_FRAC;

  assign sum_x_r = a2_r_q + p2_r_q;
  assign sum_x_i = a2_i_q + p2_i_q;
  assign sum_y_r = a2_r_q - p2_r_q;
  assign sum_y_i = a2_i_q - p2_i_q;

  always_ff @(posedge clk) begin
    a1_r_q   <= a_real_i;
    a1_i_q   <= a_imag_i;
    b1_r_q   <= b_real_i;
    b1_i_q   <= b_imag_i;
    w1_c_q   <= w_cos_i;
    w1_s_q   <= w_sin_i;
    a2_r_q   <= a1_r_q;
    a2_i_q   <= a1_i_q;
    p2_r_q   <= mul_r_sh[17:0];
    p2_i_q   <= mul_i_sh[17:0];
    // Halve then keep 16 bits
    x_real_o <= sum_x_r[16:1];
    x_imag_o <= sum_x_i[16:1];
    y_real_o <= sum_y_r[16:1];
    y_imag_o <= sum_y_i[16:1];
  end

  assign valid_o = v3_q;

endmodule

// File: source/work_bank.sv
/* FFT working register bank */

`timescale 1ns/1ps

module work_bank (
  input  logic                 clk,
  input  logic                 copy_we_i,
  input  fft_pkg::point_addr_t copy_addr_i,
  input  fft_pkg::sample_t     copy_real_i,
  input  fft_pkg::sample_t     copy_imag_i,
  input  logic                 bfly_we_i,
  input  fft_pkg::point_addr_t addr_x_i,
  input  fft_pkg::point_addr_t addr_y_i,
  input  fft_pkg::sample_t     x_real_i,
  input  fft_pkg::sample_t     x_imag_i,
  input  fft_pkg::sample_t     y_real_i,
  input  fft_pkg::sample_t     y_imag_i,
  input  fft_pkg::point_addr_t rd_a_addr_i,
  input  fft_pkg::point_addr_t rd_b_addr_i,
  input  fft_pkg::point_addr_t rd_c_addr_i,
  output fft_pkg::sample_t     rd_a_real_o,
  output fft_pkg::sample_t     rd_a_imag_o,
  output fft_pkg::sample_t     rd_b_real_o,
  output fft_pkg::sample_t     rd_b_imag_o,
  output fft_pkg::sample_t     rd_c_real_o,
  output fft_pkg::sample_t     rd_c_imag_o
);
  import fft_pkg::*;

  sample_t bank_r [N_POINTS];
  sample_t bank_i [N_POINTS];

  // Copy and butterfly writes never overlap in time
  always_ff @(posedge clk) begin
    if (copy_we_i) begin
      bank_r[copy_addr_i] <= copy_real_i;
      bank_i[copy_addr_i] <= copy_imag_i;
    end
    // x and y always hit distinct points
    if (bfly_we_i) begin
      bank_r[addr_x_i] <= x_real_i;
      bank_i[addr_x_i] <= x_imag_i;
      bank_r[addr_y_i] <= y_real_i;
      bank_i[addr_y_i] <= y_imag_i;
    end
  end

  // Butterfly operands
  assign rd_a_real_o = bank_r[rd_a_addr_i];
  assign rd_a_imag_o = bank_i[rd_a_addr_i];
  assign rd_b_real_o = bank_r[rd_b_addr_i];
  assign rd_b_imag_o = bank_i[rd_b_addr_i];
  // Host read-out
  assign rd_c_real_o = bank_r[rd_c_addr_i];
  assign rd_c_imag_o = bank_i[rd_c_addr_i];

endmodule

// File: source/fft_controller.sv
/* FFT sequencing controller */

`timescale 1ns/1ps

module fft_controller (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  start_i,
  output logic                  busy_o,
  output logic                  done_o,
  output fft_pkg::point_addr_t  copy_idx_o,
  output logic                  copy_we_o,
  output fft_pkg::point_addr_t  copy_addr_o,
  output fft_pkg::point_addr_t  rd_a_addr_o,
  output fft_pkg::point_addr_t  rd_b_addr_o,
  output fft_pkg::twiddle_idx_t twiddle_idx_o,
  output logic                  issue_o,
  output fft_pkg::point_addr_t  addr_x_o,
  output fft_pkg::point_addr_t  addr_y_o
);
  import fft_pkg::*;

  ctrl_state_e state_q;
  stage_t      stage_q;
  // Copy index, butterfly index or drain count
  point_addr_t cnt_q;
  point_addr_t bfly_j;
  point_addr_t low_bits;
  point_addr_t half;
  point_addr_t addr_a, addr_b;
  point_addr_t dly_a_q [BFLY_LATENCY];
  point_addr_t dly_b_q [BFLY_LATENCY];

  function automatic point_addr_t bit_rev(input point_addr_t v);
    point_addr_t r;
    for (int i = 0; i < LOG2_N; i++) begin
      r[i] = v[LOG2_N-1-i];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= IDLE;
      stage_q <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          // Start only honoured here
          if (start_i) begin
            state_q <= COPY;
            cnt_q   <= '0;
          end
        end
        COPY: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == point_addr_t'(N_POINTS - 1)) begin
            state_q <= STAGE;
            stage_q <= '0;
          end
        end
        STAGE: begin
          // 16 butterflies per stage
          if (cnt_q == point_addr_t'(N_POINTS / 2 - 1)) begin
            state_q <= DRAIN;
            cnt_q   <= '0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        DRAIN: begin
          // Let the pipe empty before the next stage reads
          if (cnt_q == point_addr_t'(BFLY_LATENCY - 1)) begin
            cnt_q <= '0;
            if (stage_q == stage_t'(LOG2_N - 1)) begin
              state_q <= FINISH;
            end else begin
              state_q <= STAGE;
              stage_q <= stage_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy_o  = (state_q == COPY) || (state_q == STAGE) || (state_q == DRAIN);
  assign done_o  = (state_q == FINISH);
  assign issue_o = (state_q == STAGE);

  //////////////////////////////////////////////////
  // Addressing
  //////////////////////////////////////////////////

  // Natural order read, bit-reversed write
  assign copy_idx_o  = cnt_q;
  assign copy_we_o   = (state_q == COPY);
  assign copy_addr_o = bit_rev(cnt_q);

  // Insert a zero at bit position stage into j
  assign bfly_j   = {1'b0, cnt_q[LOG2_N-2:0]};
  assign half     = point_addr_t'(1) << stage_q;
  assign low_bits = bfly_j & (half - 1'b1);
  assign addr_a   = (bfly_j << 1) - low_bits;
  assign addr_b   = addr_a + half;

  assign rd_a_addr_o   = addr_a;
  assign rd_b_addr_o   = addr_b;
  // k = pos * N / (2 * half)
  assign twiddle_idx_o = twiddle_idx_t'(low_bits << (LOG2_N - 1 - stage_q));

  // Write-back addresses ride alongside the butterfly pipe
  always_ff @(posedge clk) begin
    dly_a_q[0] <= addr_a;
    dly_b_q[0] <= addr_b;
    for (int i = 1; i < BFLY_LATENCY; i++) begin
      dly_a_q[i] <= dly_a_q[i-1];
      dly_b_q[i] <= dly_b_q[i-1];
    end
  end

  assign addr_x_o = dly_a_q[BFLY_LATENCY-1];
  assign addr_y_o = dly_b_q[BFLY_LATENCY-1];

endmodule

// File: source/fft_accel_top.sv
/* 32-point FFT accelerator */

`timescale 1ns/1ps

module fft_accel_top (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 wr_en_i,
  input  fft_pkg::host_addr_t  wr_addr_i,
  input  fft_pkg::sample_t     wr_data_i,
  input  logic                 start_i,
  input  fft_pkg::point_addr_t rd_addr_i,
  output logic                 busy_o,
  output logic                 done_o,
  output fft_pkg::sample_t     rd_real_o,
  output fft_pkg::sample_t     rd_imag_o
);
  import fft_pkg::*;

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  // Copy path
  point_addr_t  copy_idx, copy_addr;
  logic         copy_we;
  sample_t      smp_real, smp_imag;
  // Butterfly issue
  point_addr_t  rd_a_addr, rd_b_addr;
  twiddle_idx_t tw_idx;
  twiddle_t     tw_cos, tw_sin;
  logic         issue;
  sample_t      a_real, a_imag, b_real, b_imag;
  // Write-back
  logic         bfly_valid;
  point_addr_t  addr_x, addr_y;
  sample_t      x_real, x_imag, y_real, y_imag;

  sample_ram u_sample_ram (
    .clk       (clk),
    .rst_i     (rst_i),
    .busy_i    (busy_o),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .rd_idx_i  (copy_idx),
    .rd_real_o (smp_real),
    .rd_imag_o (smp_imag)
  );

  fft_controller u_ctrl (
    .clk           (clk),
    .rst_i         (rst_i),
    .start_i       (start_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .copy_idx_o    (copy_idx),
    .copy_we_o     (copy_we),
    .copy_addr_o   (copy_addr),
    .rd_a_addr_o   (rd_a_addr),
    .rd_b_addr_o   (rd_b_addr),
    .twiddle_idx_o (tw_idx),
    .issue_o       (issue),
    .addr_x_o      (addr_x),
    .addr_y_o      (addr_y)
  );

  twiddle_rom u_twiddle_rom (
    .idx_i (tw_idx),
    .cos_o (tw_cos),
    .sin_o (tw_sin)
  );

  butterfly_unit u_bfly (
    .clk      (clk),
    .rst_i    (rst_i),
    .valid_i  (issue),
    .a_real_i (a_real),
    .a_imag_i (a_imag),
    .b_real_i (b_real),
    .b_imag_i (b_imag),
    .w_cos_i  (tw_cos),
    .w_sin_i  (tw_sin),
    .valid_o  (bfly_valid),
    .x_real_o (x_real),
    .x_imag_o (x_imag),
    .y_real_o (y_real),
    .y_imag_o (y_imag)
  );

  // Port c is the host read-out
  work_bank u_work_bank (
    .clk         (clk),
    .copy_we_i   (copy_we),
    .copy_addr_i (copy_addr),
    .copy_real_i (smp_real),
    .copy_imag_i (smp_imag),
    .bfly_we_i   (bfly_valid),
    .addr_x_i    (addr_x),
    .addr_y_i    (addr_y),
    .x_real_i    (x_real),
    .x_imag_i    (x_imag),
    .y_real_i    (y_real),
    .y_imag_i    (y_imag),
    .rd_a_addr_i (rd_a_addr),
    .rd_b_addr_i (rd_b_addr),
    .rd_c_addr_i (rd_addr_i),
    .rd_a_real_o (a_real),
    .rd_a_imag_o (a_imag),
    .rd_b_real_o (b_real),
    .rd_b_imag_o (b_imag),
    .rd_c_real_o (rd_real_o),
    .rd_c_imag_o (rd_imag_o)
  );

endmodule

// File: verification/fft_accel_props.sv
/* Controller strobe assertions */

`timescale 1ns/1ps

module fft_accel_props (
  input logic clk,
  input logic rst_i,
  input logic busy_i,
  input logic done_i,
  input logic issue_i
);

  integer prop_errors = 0;

  // Done lasts one cycle
  done_single: assert property (@(posedge clk) disable iff (rst_i) done_i |=> !done_i)
    else begin
      prop_errors = prop_errors + 1;
      $error("done held high for more than one cycle");
    end

  // Busy drops exactly when done rises
  busy_falls_with_done: assert property (@(posedge clk) disable iff (rst_i)
    $fell(busy_i) |-> done_i)
    else begin
      prop_errors = prop_errors + 1;
      $error("busy fell without done");
    end

  // Done only ever arrives as busy drops
  done_ends_busy: assert property (@(posedge clk) disable iff (rst_i)
    done_i |-> $fell(busy_i))
    else begin
      prop_errors = prop_errors + 1;
      $error("done without busy falling in the same cycle");
    end

  // A new stage waits out the three drain cycles
  issue_after_drain: assert property (@(posedge clk) disable iff (rst_i)
    $rose(issue_i) |-> !$past(issue_i, 2) && !$past(issue_i, 3))
    else begin
      prop_errors = prop_errors + 1;
      $error("butterfly issue inside the drain window");
    end

endmodule

bind fft_controller fft_accel_props u_props (
  .clk     (clk),
  .rst_i   (rst_i),
  .busy_i  (busy_o),
  .done_i  (done_o),
  .issue_i (issue_o)
);

// File: verification/fft_checker.sv
/* FFT result and timing checker */

`timescale 1ns/1ps

module fft_checker (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  logic                 busy_i,
  input  logic                 done_i,
  input  fft_pkg::sample_t     rd_real_i,
  input  fft_pkg::sample_t     rd_imag_i,
  input  fft_pkg::sample_t     exp_re_i [32],
  input  fft_pkg::sample_t     exp_im_i [32],
  output fft_pkg::point_addr_t rd_addr_o,
  output integer               value_errors_o,
  output integer               timing_errors_o,
  output integer               checks_o
);
  import fft_pkg::*;

  logic   running;
  integer cyc;

  initial begin
    rd_addr_o       = '0;
    value_errors_o  = 0;
    timing_errors_o = 0;
    checks_o        = 0;
    running         = 1'b0;
    cyc             = 0;
  end

  //////////////////////////////////////////////////
  // Busy and done timing, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_i) begin
      running = 1'b0;
    end else begin
      if (running) begin
        cyc++;
        if (cyc < RUN_CYCLES && (busy_i !== 1'b1 || done_i !== 1'b0)) begin
          timing_errors_o++;
          $display("MISMATCH at %0t: run cycle %0d busy %b done %b, expected busy 1 done 0",
                   $time, cyc, busy_i, done_i);
        end
        if (cyc == RUN_CYCLES) begin
          running = 1'b0;
          if (busy_i !== 1'b0 || done_i !== 1'b1) begin
            timing_errors_o++;
            $display("MISMATCH at %0t: run cycle %0d busy %b done %b, expected busy 0 done 1",
                     $time, cyc, busy_i, done_i);
          end
        end
      end else if (busy_i !== 1'b0 || done_i !== 1'b0) begin
        // Covers stray done pulses too
        timing_errors_o++;
        $display("MISMATCH at %0t: idle busy %b done %b, expected both low",
                 $time, busy_i, done_i);
      end
      // Start is taken at the next edge only when idle
      if (!running && start_i === 1'b1 && busy_i === 1'b0 && done_i === 1'b0) begin
        running = 1'b1;
        cyc     = 0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Result sweep over the read port
  //////////////////////////////////////////////////

  task automatic sweep_results(input integer run);
    for (int i = 0; i < N_POINTS; i++) begin
      @(posedge clk);
      #2;
      rd_addr_o = point_addr_t'(i);
      @(negedge clk);
      checks_o++;
      if (rd_real_i !== exp_re_i[i] || rd_imag_i !== exp_im_i[i]) begin
        value_errors_o++;
        $display("MISMATCH at %0t: run %0d point %0d got (%0d, %0d) expected (%0d, %0d)",
                 $time, run, i, rd_real_i, rd_imag_i, exp_re_i[i], exp_im_i[i]);
      end
    end
  endtask

endmodule

// File: verification/tb_fft_accel.sv
/* FFT accelerator testbench */

`timescale 1ns/1ps

module tb_fft_accel;
  import fft_pkg::*;

  localparam int    NUM_VECTORS  = 3;
  // Pattern runs plus one rerun of the last vector
  localparam int    NUM_RUNS     = NUM_VECTORS + 1;
  localparam int    LIMIT_CYCLES = NUM_RUNS * (64 + RUN_CYCLES + 40) + 100;
  localparam string PAT_FILE     = "verification/fft_patterns.txt";

  logic        clk;
  logic        rst_i;
  logic        wr_en_i;
  host_addr_t  wr_addr_i;
  sample_t     wr_data_i;
  logic        start_i;
  point_addr_t rd_addr;
  logic        busy_o;
  logic        done_o;
  sample_t     rd_real_o;
  sample_t     rd_imag_o;

  // Flat pattern storage, vector * 32 + point
  integer  in_re [NUM_VECTORS*N_POINTS];
  integer  in_im [NUM_VECTORS*N_POINTS];
  integer  ex_re [NUM_VECTORS*N_POINTS];
  integer  ex_im [NUM_VECTORS*N_POINTS];
  // Expected values of the current run
  sample_t exp_re [N_POINTS];
  sample_t exp_im [N_POINTS];

  integer seed;
  integer tb_errors;
  integer value_errors;
  integer timing_errors;
  integer checks;
  integer total;
  logic   load_ok;

  fft_accel_top dut (
    .clk       (clk),
    .rst_i     (rst_i),
    .wr_en_i   (wr_en_i),
    .wr_addr_i (wr_addr_i),
    .wr_data_i (wr_data_i),
    .start_i   (start_i),
    .rd_addr_i (rd_addr),
    .busy_o    (busy_o),
    .done_o    (done_o),
    .rd_real_o (rd_real_o),
    .rd_imag_o (rd_imag_o)
  );

  fft_checker u_chk (
    .clk             (clk),
    .rst_i           (rst_i),
    .start_i         (start_i),
    .busy_i          (busy_o),
    .done_i          (done_o),
    .rd_real_i       (rd_real_o),
    .rd_imag_i       (rd_imag_o),
    .exp_re_i        (exp_re),
    .exp_im_i        (exp_im),
    .rd_addr_o       (rd_addr),
    .value_errors_o  (value_errors),
    .timing_errors_o (timing_errors),
    .checks_o        (checks)
  );

  //////////////////////////////////////////////////
  // Clock and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles, run did not complete", LIMIT_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////

  task automatic load_patterns();
    integer fd;
    integer idx, ir, ii, er, ei;
    integer row;
    string  line;
    row = 0;
    fd  = $fopen(PAT_FILE, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open pattern file %s", PAT_FILE);
      tb_errors++;
    end else begin
      while (!$feof(fd) && row < NUM_VECTORS * N_POINTS) begin
        void'($fgets(line, fd));
        // 8'h23 marks a comment line
        if (line.len() > 0 && line.getc(0) != 8'h23) begin
          if ($sscanf(line, "%d %d %d %d %d", idx, ir, ii, er, ei) == 5) begin
            if (idx != row % N_POINTS) begin
              $display("ERROR: pattern row %0d has point index %0d", row, idx);
              tb_errors++;
            end
            in_re[row] = ir;
            in_im[row] = ii;
            ex_re[row] = er;
            ex_im[row] = ei;
            row++;
          end
        end
      end
      $fclose(fd);
      load_ok = (row == NUM_VECTORS * N_POINTS);
      if (!load_ok) begin
        $display("ERROR: pattern file holds only %0d of %0d rows", row, NUM_VECTORS * N_POINTS);
        tb_errors++;
      end
    end
  endtask

  // Real half then imaginary half, one write per cycle
  task automatic write_vector(input integer v);
    for (int i = 0; i < N_POINTS; i++) begin
      @(posedge clk);
      #2;
      wr_en_i   = 1'b1;
      wr_addr_i = host_addr_t'(i);
      wr_data_i = sample_t'(in_re[v*N_POINTS+i]);
      @(posedge clk);
      #2;
      wr_addr_i = host_addr_t'(N_POINTS + i);
      wr_data_i = sample_t'(in_im[v*N_POINTS+i]);
      exp_re[i] = sample_t'(ex_re[v*N_POINTS+i]);
      exp_im[i] = sample_t'(ex_im[v*N_POINTS+i]);
    end
    @(posedge clk);
    #2;
    wr_en_i = 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge clk);
    #2;
    start_i = 1'b1;
    @(posedge clk);
    #2;
    start_i = 1'b0;
  endtask

  // Random writes while busy, all must be dropped
  task automatic write_garbage(input integer n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #2;
      wr_en_i   = 1'b1;
      wr_addr_i = host_addr_t'($random(seed));
      wr_data_i = sample_t'($random(seed));
    end
    @(posedge clk);
    #2;
    wr_en_i = 1'b0;
  endtask

  task automatic wait_for_done();
    integer n;
    logic   seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < RUN_CYCLES + 8) begin
      @(negedge clk);
      seen = done_o;
      n++;
    end
    if (!seen) begin
      $display("ERROR: done pulse did not arrive within %0d cycles", RUN_CYCLES + 8);
      tb_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    rst_i     = 1'b1;
    wr_en_i   = 1'b0;
    wr_addr_i = '0;
    wr_data_i = '0;
    start_i   = 1'b0;
    seed      = 32'hce1b8318;
    tb_errors = 0;
    load_ok   = 1'b0;
    for (int i = 0; i < N_POINTS; i++) begin
      exp_re[i] = '0;
      exp_im[i] = '0;
    end
    load_patterns();
    repeat (16) @(posedge clk);
    #2;
    rst_i = 1'b0;
    // Idle stretch, checker expects busy and done low
    repeat (4) @(posedge clk);
    if (load_ok) begin
      for (int v = 0; v < NUM_VECTORS; v++) begin
        write_vector(v);
        pulse_start();
        if (v == NUM_VECTORS - 1) begin
          write_garbage(20);
        end
        wait_for_done();
        u_chk.sweep_results(v);
      end
      // Same samples again, plus a start in the middle of the run
      pulse_start();
      repeat (40) @(posedge clk);
      #2;
      start_i = 1'b1;
      @(posedge clk);
      #2;
      start_i = 1'b0;
      wait_for_done();
      u_chk.sweep_results(NUM_VECTORS);
    end
    repeat (4) @(posedge clk);
    total = tb_errors + value_errors + timing_errors + dut.u_ctrl.u_props.prop_errors;
    $display("Checks %0d, errors: value %0d, timing %0d, tb %0d, assertion %0d",
             checks, value_errors, timing_errors, tb_errors, dut.u_ctrl.u_props.prop_errors);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: verification/fft_patterns.txt
# columns: point in_real in_imag exp_real exp_imag (signed decimal)
# three vectors of 32 rows: impulse, complex constant, two-sample pulse
0 16000 -8000 500 -250
1 0 0 500 -250
2 0 0 500 -250
3 0 0 500 -250
4 0 0 500 -250
5 0 0 500 -250
6 0 0 500 -250
7 0 0 500 -250
8 0 0 500 -250
9 0 0 500 -250
10 0 0 500 -250
11 0 0 500 -250
12 0 0 500 -250
13 0 0 500 -250
14 0 0 500 -250
15 0 0 500 -250
16 0 0 500 -250
17 0 0 500 -250
18 0 0 500 -250
19 0 0 500 -250
20 0 0 500 -250
21 0 0 500 -250
22 0 0 500 -250
23 0 0 500 -250
24 0 0 500 -250
25 0 0 500 -250
26 0 0 500 -250
27 0 0 500 -250
28 0 0 500 -250
29 0 0 500 -250
30 0 0 500 -250
31 0 0 500 -250
0 1000 -300 1000 -300
1 1000 -300 0 0
2 1000 -300 0 0
3 1000 -300 0 0
4 1000 -300 0 0
5 1000 -300 0 0
6 1000 -300 0 0
7 1000 -300 0 0
8 1000 -300 0 0
9 1000 -300 0 0
10 1000 -300 0 0
11 1000 -300 0 0
12 1000 -300 0 0
13 1000 -300 0 0
14 1000 -300 0 0
15 1000 -300 0 0
16 1000 -300 0 0
17 1000 -300 0 0
18 1000 -300 0 0
19 1000 -300 0 0
20 1000 -300 0 0
21 1000 -300 0 0
22 1000 -300 0 0
23 1000 -300 0 0
24 1000 -300 0 0
25 1000 -300 0 0
26 1000 -300 0 0
27 1000 -300 0 0
28 1000 -300 0 0
29 1000 -300 0 0
30 1000 -300 0 0
31 1000 -300 0 0
0 8000 4000 762 125
1 16384 0 752 25
2 0 0 723 -71
3 0 0 675 -160
4 0 0 612 -238
5 0 0 534 -301
6 0 0 445 -349
7 0 0 349 -378
8 0 0 250 -387
9 0 0 150 -378
10 0 0 54 -349
11 0 0 -35 -301
12 0 0 -113 -238
13 0 0 -176 -160
14 0 0 -224 -71
15 0 0 -253 25
16 0 0 -262 125
17 0 0 -252 225
18 0 0 -223 321
19 0 0 -176 409
20 0 0 -112 487
21 0 0 -34 551
22 0 0 54 598
23 0 0 150 627
24 0 0 250 637
25 0 0 350 627
26 0 0 446 598
27 0 0 534 551
28 0 0 612 487
29 0 0 676 409
30 0 0 723 321
31 0 0 752 225

// File: compile.f
source/fft_pkg.sv
source/sample_ram.sv
source/twiddle_rom.sv
source/butterfly_unit.sv
source/work_bank.sv
source/fft_controller.sv
source/fft_accel_top.sv
verification/fft_accel_props.sv
verification/fft_checker.sv
verification/tb_fft_accel.sv

// File: Makefile
# Verilator flow for the FFT accelerator

VERILATOR ?= verilator
TOP       ?= tb_fft_accel
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
